// File: dv/laneMonitor.sv
// Writeback checker for the lane testbench
// Expected queue in issue order, compare on every wbValid pulse, closing counts
`timescale 1ns/10ps
`include "lane_config.svh"

module laneMonitor (
	input logic                  clock,
	input logic                  rstN,
	input logic                  wbValid,
	input logic [`LANE_IDW-1:0]  wbId,
	input logic [`LANE_XLEN-1:0] wbVal
);

	string                 nameQ [$];	// Test that issued each op
	logic [`LANE_IDW-1:0]  idQ [$];
	logic [`LANE_XLEN-1:0] valQ [$];
	int                    checkCount = 0;
	int                    errCount = 0;
	int                    mismatchCount = 0;
	int                    missingCount = 0;
	int                    extraCount = 0;

	task automatic pushExpect(input string name, input logic [`LANE_IDW-1:0] id,
		input logic [`LANE_XLEN-1:0] val);
		nameQ.push_back(name);
		idQ.push_back(id);
		valQ.push_back(val);
	endtask

	// Mid-cycle sample, writeback flops are settled
	always @(negedge clock) begin : compareWb
		string                 name;
		logic [`LANE_IDW-1:0]  id;
		logic [`LANE_XLEN-1:0] val;
		if (rstN && wbValid) begin
			if (idQ.size() == 0) begin
				extraCount++;
				errCount++;
				$display("Writeback to r%0d arrived with no operation outstanding", wbId);
			end else begin
				name = nameQ.pop_front();
				id   = idQ.pop_front();
				val  = valQ.pop_front();
				checkCount++;
				if ((id != wbId) || (val != wbVal)) begin
					mismatchCount++;
					errCount++;
					$display("ERR %s: expected r%0d=%08h, actual r%0d=%08h",
						name, id, val, wbId, wbVal);
				end
			end
		end
	end

	// Assertion failures of the bound checker join the total
	task automatic report(input int assertFails);
		if (idQ.size() != 0) begin
			missingCount = idQ.size();
			errCount += missingCount;
			$display("%0d expected writebacks never arrived, first one from test %s",
				missingCount, nameQ[0]);
		end
		errCount += assertFails;
		$display("Checked %0d, %0d errors (%0d wrong, %0d missing, %0d extra, %0d assertion)",
			checkCount, errCount, mismatchCount, missingCount, extraCount, assertFails);
	endtask

endmodule

// File: dv/laneTb.sv
// Testbench top for the execute lane
// Clock, reset, xorshift stimulus, req/ack driver, reference model, timeout
`timescale 1ns/10ps
`include "lane_config.svh"

module laneTb;

	localparam int NumInit    = 15;	// MOVI into r1..r15
	localparam int NumAlu     = 60;
	localparam int NumDelay   = 40;
	localparam int NumPred    = 20;	// Groups of one compare and three predicated ops
	localparam int NumZero    = 20;
	localparam int TotalOps   = NumInit + NumAlu + NumDelay + 4 * NumPred + NumZero;
	localparam int CycleLimit = TotalOps * 8 + 100;

	logic                  clock = 1'b0;
	logic                  rstN;
	logic                  opReq;
	lanePkg::laneOpT       opWord;
	logic                  opAck;
	logic                  wbValid;
	logic [`LANE_IDW-1:0]  wbId;
	logic [`LANE_XLEN-1:0] wbVal;

	logic [31:0]           rngState = 32'd46;
	logic [`LANE_XLEN-1:0] modelRegs [`LANE_NREGS];	// Model register file
	logic                  modelT;
	int                    cycleCount = 0;
	string                 testName = "reset";

	lanePkg::opCodeT aluCodes [6] = '{lanePkg::ADD, lanePkg::SUB, lanePkg::AND,
		lanePkg::OR, lanePkg::XOR, lanePkg::MOVI};
	lanePkg::opCodeT delayCodes [3] = '{lanePkg::MUL, lanePkg::MULH, lanePkg::SAR};
	lanePkg::opCodeT writeCodes [9] = '{lanePkg::ADD, lanePkg::SUB, lanePkg::AND,
		lanePkg::OR, lanePkg::XOR, lanePkg::MOVI, lanePkg::MUL, lanePkg::MULH, lanePkg::SAR};

	always #2 clock = ~clock;	// 4 ns period

	laneTop dut (
		.clock   (clock),
		.rstN    (rstN),
		.opReq   (opReq),
		.opWord  (opWord),
		.opAck   (opAck),
		.wbValid (wbValid),
		.wbId    (wbId),
		.wbVal   (wbVal)
	);

	laneMonitor mon (
		.clock   (clock),
		.rstN    (rstN),
		.wbValid (wbValid),
		.wbId    (wbId),
		.wbVal   (wbVal)
	);

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic lanePkg::laneOpT makeOp(input lanePkg::opCodeT code, input logic pred,
		input logic sense, input logic useImm, input logic [`LANE_IDW-1:0] rd,
		input logic [`LANE_IDW-1:0] rs, input logic [`LANE_OPNDW-1:0] opnd);
		lanePkg::laneOpT op;
		op.opCode      = code;
		op.predicated  = pred;
		op.predSense   = sense;
		op.useImm      = useImm;
		op.rd          = rd;
		op.rs          = rs;
		op.operand.imm = opnd;	// Rt sits in the low bits of the same field
		return op;
	endfunction

	// Expected writeback of one op, updates model registers and T
	function automatic logic predictWb(input lanePkg::laneOpT op,
		output logic [`LANE_IDW-1:0] expId, output logic [`LANE_XLEN-1:0] expVal);
		logic [`LANE_XLEN-1:0]          a;
		logic [`LANE_XLEN-1:0]          b;
		logic signed [2*`LANE_XLEN-1:0] prod;
		logic                           writes;
		expId  = op.rd;
		expVal = '0;
		writes = 1'b1;
		a = modelRegs[op.rs];
		if (op.useImm || (op.opCode == lanePkg::MOVI)) begin
			b = {{(`LANE_XLEN-`LANE_OPNDW){op.operand.imm[`LANE_OPNDW-1]}}, op.operand.imm};
		end else begin
			b = modelRegs[op.operand.regView.rt];
		end
		prod = $signed({{`LANE_XLEN{a[`LANE_XLEN-1]}}, a}) *
			$signed({{`LANE_XLEN{b[`LANE_XLEN-1]}}, b});
		if (op.predicated && (modelT != op.predSense)) begin
			return 1'b0;	// Cancelled, T untouched
		end
		case (op.opCode)
			lanePkg::ADD:   expVal = a + b;
			lanePkg::SUB:   expVal = a - b;
			lanePkg::AND:   expVal = a & b;
			lanePkg::OR:    expVal = a | b;
			lanePkg::XOR:   expVal = a ^ b;
			lanePkg::MOVI:  expVal = b;
			lanePkg::MUL:   expVal = prod[`LANE_XLEN-1:0];
			lanePkg::MULH:  expVal = prod[2*`LANE_XLEN-1:`LANE_XLEN];
			lanePkg::SAR:   expVal = $signed(a) >>> b[4:0];
			lanePkg::CMPEQ: begin
				modelT = (a == b);
				writes = 1'b0;
			end
			lanePkg::CMPGT: begin
				modelT = ($signed(a) > $signed(b));
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && (op.rd != '0)) begin
			modelRegs[op.rd] = expVal;
		end
		return writes && (op.rd != '0);	// r0 never reported
	endfunction

	// One full four-phase transfer, req held a random 0..3 extra cycles
	task automatic issueOp(input lanePkg::laneOpT op);
		logic [31:0]           hold;
		logic                  expValid;
		logic [`LANE_IDW-1:0]  expId;
		logic [`LANE_XLEN-1:0] expVal;
		hold     = nextRandom() % 4;
		expValid = predictWb(op, expId, expVal);
		if (expValid) begin
			mon.pushExpect(testName, expId, expVal);
		end
		@(posedge clock);
		opWord <= op;
		opReq  <= 1'b1;
		do @(negedge clock); while (!opAck);
		repeat (hold) @(posedge clock);
		@(posedge clock);
		opReq <= 1'b0;
		do @(negedge clock); while (opAck);
	endtask

	task automatic loadRegisters();
		logic [`LANE_OPNDW-1:0] imm;
		testName = "load";
		for (int i = 1; i < NumInit + 1; i++) begin
			imm = (i == 1) ? 16'hff80 : nextRandom() >> 16;	// r1 gets a negative
			issueOp(makeOp(lanePkg::MOVI, 1'b0, 1'b0, 1'b1, i[`LANE_IDW-1:0], '0, imm));
		end
	endtask

	task automatic runAluTest();
		logic [31:0] r;
		logic [31:0] v;
		logic        useImm;
		testName = "alu";
		for (int i = 0; i < NumAlu; i++) begin
			r = nextRandom();
			v = nextRandom();
			useImm = r[4];
			if (i % 4 == 0) begin
				useImm = 1'b1;	// Force negative immediate
				v[15]  = 1'b1;
			end
			issueOp(makeOp(aluCodes[r % 6], 1'b0, 1'b0, useImm, r[11:8], r[15:12], v[15:0]));
		end
	endtask

	task automatic runDelayTest();
		logic [31:0] r;
		logic [31:0] v;
		testName = "delay";
		for (int i = 0; i < NumDelay; i++) begin
			r = nextRandom();
			v = nextRandom();
			issueOp(makeOp(delayCodes[r % 3], 1'b0, 1'b0, r[4], r[11:8], r[15:12], v[15:0]));
		end
	endtask

	task automatic runPredTest();
		logic [31:0] r;
		logic [31:0] v;
		testName = "predicate";
		for (int i = 0; i < NumPred; i++) begin
			r = nextRandom();
			v = nextRandom();
			if (r[0]) begin
				// Rt equal to Rs half the time so CMPEQ can pass
				v[3:0] = r[1] ? r[15:12] : v[3:0];
				issueOp(makeOp(lanePkg::CMPEQ, 1'b0, 1'b0, 1'b0, r[11:8], r[15:12], v[15:0]));
			end else begin
				issueOp(makeOp(lanePkg::CMPGT, 1'b0, 1'b0, r[2], r[11:8], r[15:12], v[15:0]));
			end
			for (int j = 0; j < 3; j++) begin
				r = nextRandom();
				v = nextRandom();
				issueOp(makeOp(writeCodes[r % 9], 1'b1, r[5], r[4], r[11:8], r[15:12], v[15:0]));
			end
		end
	endtask

	task automatic runZeroTest();
		logic [31:0] r;
		logic [31:0] v;
		testName = "zeroreg";
		for (int i = 0; i < NumZero; i++) begin
			r = nextRandom();
			v = nextRandom();
			if (i % 2 == 0) begin
				issueOp(makeOp(writeCodes[r % 9], 1'b0, 1'b0, r[4], '0, r[15:12], v[15:0]));
			end else begin
				v[3:0] = '0;	// Rt is r0 as well
				issueOp(makeOp(aluCodes[r % 5], 1'b0, 1'b0, 1'b0, r[11:8], '0, v[15:0]));
			end
		end
	endtask

	// Cycle limit for a stuck handshake
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Run stopped at cycle %0d before all operations were issued", cycleCount);
			mon.report(dut.chk.failCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		rstN   = 1'b0;
		opReq  = 1'b0;
		opWord = '0;
		modelT = 1'b0;
		for (int i = 0; i < `LANE_NREGS; i++) begin
			modelRegs[i] = '0;
		end
		repeat (8) @(posedge clock);
		rstN <= 1'b1;
		loadRegisters();
		runAluTest();
		runDelayTest();
		runPredTest();
		runZeroTest();
		repeat (6) @(posedge clock);	// Drain last writeback, catch strays
		mon.report(dut.chk.failCount);
		if (mon.errCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: dv/lane_checker.sv
// Handshake and writeback assertions, bound into laneTop
`timescale 1ns/10ps

module laneChecker (
	input logic clock,
	input logic rstN,
	input logic opReq,
	input logic opAck,
	input logic accept,
	input logic wbValid
);

	int failCount = 0;	// Failed assertions, part of the final verdict

	ackOnAccept: assert property (@(posedge clock) disable iff (!rstN)
		(opReq && !opAck) |=> opAck) else begin
		$error("opAck not raised after a request");
		failCount++;
	end

	ackRiseNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(opAck) |-> $past(opReq)) else begin
		$error("opAck rose without opReq");
		failCount++;
	end

	ackHeld: assert property (@(posedge clock) disable iff (!rstN)
		(opAck && opReq) |=> opAck) else begin
		$error("opAck dropped while opReq high");
		failCount++;
	end

	ackFallNeedsDrop: assert property (@(posedge clock) disable iff (!rstN)
		$fell(opAck) |-> !$past(opReq)) else begin
		$error("opAck fell before opReq dropped");
		failCount++;
	end

	// Registered two edges after accept, so three samples later
	wbLatency: assert property (@(posedge clock) disable iff (!rstN)
		wbValid |-> $past(accept, 3)) else begin
		$error("writeback not two edges after accept");
		failCount++;
	end

	wbSinglePulse: assert property (@(posedge clock) disable iff (!rstN)
		wbValid |=> !wbValid) else begin
		$error("wbValid high for more than one cycle");
		failCount++;
	end

endmodule

bind laneTop laneChecker chk (
	.clock   (clock),
	.rstN    (rstN),
	.opReq   (opReq),
	.opAck   (opAck),
	.accept  (accept),
	.wbValid (wbValid)
);

// File: hdl/execStage1.sv
// First execute stage
// Single cycle ALU, T flag and predicate check, start of MUL/MULH/SAR
`timescale 1ns/10ps
`include "lane_config.svh"

module execStage1 (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    opValid,
	input  lanePkg::laneOpT         op,
	input  logic [`LANE_XLEN-1:0]   valRs,
	input  logic [`LANE_XLEN-1:0]   valRt,
	output logic [`LANE_IDW-1:0]    rn1Id,		// Destination for EX2
	output logic [`LANE_XLEN-1:0]   rn1Val,
	output lanePkg::opCodeT         delayKind,	// Work left for EX2
	output logic [2*`LANE_XLEN-1:0] delayVal,
	output logic                    opCancel
);

	logic                           tFlag;
	logic                           opEnable;
	lanePkg::opCodeT                opCode1;
	logic                           doWrite;
	logic [`LANE_XLEN-1:0]          nextVal;
	lanePkg::opCodeT                nextKind;
	logic [2*`LANE_XLEN-1:0]        nextDelay;
	logic                           nextT;
	logic signed [2*`LANE_XLEN-1:0] product;

	// Full signed product, halves picked in EX2
	assign product = $signed(valRs) * $signed(valRt);

	// Predicate check against current T
	assign opEnable = !op.predicated || (tFlag == op.predSense);
	assign opCode1  = (opValid && opEnable) ? op.opCode : lanePkg::NOP;

	always_comb begin
		doWrite   = 1'b1;	// Most ops write rd
		nextVal   = '0;
		nextKind  = lanePkg::NOP;
		nextDelay = '0;
		nextT     = tFlag;
		case (opCode1)
			lanePkg::ADD:   nextVal = valRs + valRt;
			lanePkg::SUB:   nextVal = valRs - valRt;
			lanePkg::AND:   nextVal = valRs & valRt;
			lanePkg::OR:    nextVal = valRs | valRt;
			lanePkg::XOR:   nextVal = valRs ^ valRt;
			lanePkg::MOVI:  nextVal = valRt;	// Operand already extended
			lanePkg::CMPEQ: begin
				doWrite = 1'b0;
				nextT   = (valRs == valRt);
			end
			lanePkg::CMPGT: begin
				doWrite = 1'b0;
				nextT   = ($signed(valRs) > $signed(valRt));
			end
			lanePkg::MUL, lanePkg::MULH: begin
				nextKind  = opCode1;
				nextDelay = product;
			end
			lanePkg::SAR: begin
				// Amount above source
				nextKind  = lanePkg::SAR;
				nextDelay = {{(`LANE_XLEN-5){1'b0}}, valRt[4:0], valRs};
			end
			default: doWrite = 1'b0;	// NOP and cancelled ops
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tFlag     <= 1'b0;
			rn1Id     <= '0;
			delayKind <= lanePkg::NOP;
			opCancel  <= 1'b0;
		end else begin
			tFlag     <= nextT;
			// Id 0 means no write, cancelled op keeps rd for EX2 to redirect
			rn1Id     <= (doWrite || (opValid && !opEnable)) ? op.rd : '0;
			delayKind <= nextKind;
			opCancel  <= opValid && !opEnable;
		end
	end

	// Payload, qualified by rn1Id
	always_ff @(posedge clock) begin
		rn1Val   <= nextVal;	// Zero for delayed ops
		delayVal <= nextDelay;
	end

endmodule

// File: hdl/execStage2.sv
// Second execute stage
// Forwards EX1 result or completes delayed ops, drives writeback
`timescale 1ns/10ps
`include "lane_config.svh"

module execStage2 (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic [`LANE_IDW-1:0]    rn1Id,
	input  logic [`LANE_XLEN-1:0]   rn1Val,
	input  lanePkg::opCodeT         delayKind,
	input  logic [2*`LANE_XLEN-1:0] delayVal,
	input  logic                    opCancel,
	output logic                    wbValid,
	output logic [`LANE_IDW-1:0]    wbId,
	output logic [`LANE_XLEN-1:0]   wbVal
);

	logic [`LANE_IDW-1:0]  rn2Id;
	logic [`LANE_XLEN-1:0] rn2Val;
	logic [`LANE_XLEN-1:0] sarSrc;
	logic [4:0]            sarAmt;

	// Shift operands as packed by EX1
	assign sarSrc = delayVal[`LANE_XLEN-1:0];
	assign sarAmt = delayVal[`LANE_XLEN +: 5];

	always_comb begin
		rn2Id  = rn1Id;		// Forward by default
		rn2Val = rn1Val;
		case (delayKind)
			lanePkg::MUL:  rn2Val = delayVal[`LANE_XLEN-1:0];
			lanePkg::MULH: rn2Val = delayVal[2*`LANE_XLEN-1:`LANE_XLEN];
			lanePkg::SAR:  rn2Val = $signed(sarSrc) >>> sarAmt;	// Sign fill
			default: begin
			end
		endcase

		// Cancelled op lands on the zero register
		if (opCancel) begin
			rn2Id = '0;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			wbId    <= '0;
		end else begin
			wbValid <= (rn2Id != '0);	// Register 0 never reported
			wbId    <= rn2Id;
		end
	end

	always_ff @(posedge clock) begin
		wbVal <= rn2Val;
	end

endmodule

// File: hdl/lanePkg.sv
// Shared types of the execute lane
// Operation codes, operand union, operation word
`include "lane_config.svh"

package lanePkg;

	// Operation codes, 4 bits
	typedef enum logic [3:0] {
		NOP,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		MOVI,	// Immediate move
		CMPEQ,	// Sets T, no writeback
		CMPGT,	// Signed, sets T
		MUL,	// Low half, finished in EX2
		MULH,	// High half, finished in EX2
		SAR	// Arithmetic shift, finished in EX2
	} opCodeT;

	// Operand field, two readings of one word
	typedef union packed {
		struct packed {
			logic [`LANE_OPNDW-`LANE_IDW-1:0] pad;	// Unused upper bits
			logic [`LANE_IDW-1:0]             rt;	// Source B id
		} regView;
		logic [`LANE_OPNDW-1:0] imm;	// Sign extended on use
	} operandT;

	// One issued operation
	typedef struct packed {
		opCodeT               opCode;
		logic                 predicated;	// Runs only if T matches
		logic                 predSense;
		logic                 useImm;		// Operand is immediate
		logic [`LANE_IDW-1:0] rd;
		logic [`LANE_IDW-1:0] rs;
		operandT              operand;
	} laneOpT;

endpackage

// File: hdl/laneTop.sv
// Execute lane top level
// Issue handshake, operand fetch, register file and both execute stages
`timescale 1ns/10ps
`include "lane_config.svh"

module laneTop (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  opReq,
	input  lanePkg::laneOpT       opWord,
	output logic                  opAck,
	output logic                  wbValid,
	output logic [`LANE_IDW-1:0]  wbId,
	output logic [`LANE_XLEN-1:0] wbVal
);

	lanePkg::operandT        opnd;
	logic                    accept;
	logic [`LANE_XLEN-1:0]   rdValA;
	logic [`LANE_XLEN-1:0]   rdValB;
	logic [`LANE_XLEN-1:0]   immExt;
	logic [`LANE_XLEN-1:0]   opndVal;
	logic                    issueValid;	// One cycle per accepted op
	lanePkg::laneOpT         issueOp;
	logic [`LANE_XLEN-1:0]   issueRs;
	logic [`LANE_XLEN-1:0]   issueRt;
	logic [`LANE_IDW-1:0]    rn1Id;
	logic [`LANE_XLEN-1:0]   rn1Val;
	lanePkg::opCodeT         delayKind;
	logic [2*`LANE_XLEN-1:0] delayVal;
	logic                    opCancel;

	assign opnd   = opWord.operand;
	assign accept = opReq && !opAck;	// First edge of a new request

	// Operand B, register view or immediate view
	assign immExt  = {{(`LANE_XLEN-`LANE_OPNDW){opnd.imm[`LANE_OPNDW-1]}}, opnd.imm};
	assign opndVal = (opWord.useImm || (opWord.opCode == lanePkg::MOVI)) ? immExt : rdValB;

	// Four phase ack, drops one edge after req drops
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			opAck      <= 1'b0;
			issueValid <= 1'b0;
		end else begin
			issueValid <= accept;
			if (accept) begin
				opAck <= 1'b1;
			end else if (!opReq) begin
				opAck <= 1'b0;
			end
		end
	end

	// Operation and operands captured at accept
	always_ff @(posedge clock) begin
		if (accept) begin
			issueOp <= opWord;
			issueRs <= rdValA;
			issueRt <= opndVal;
		end
	end

	regFile uRegFile (
		.clock  (clock),
		.rstN   (rstN),
		.rdIdA  (opWord.rs),
		.rdIdB  (opnd.regView.rt),
		.rdValA (rdValA),
		.rdValB (rdValB),
		.wrEn   (wbValid),
		.wrId   (wbId),
		.wrVal  (wbVal)
	);

	execStage1 uExec1 (
		.clock     (clock),
		.rstN      (rstN),
		.opValid   (issueValid),
		.op        (issueOp),
		.valRs     (issueRs),
		.valRt     (issueRt),
		.rn1Id     (rn1Id),
		.rn1Val    (rn1Val),
		.delayKind (delayKind),
		.delayVal  (delayVal),
		.opCancel  (opCancel)
	);

	execStage2 uExec2 (
		.clock     (clock),
		.rstN      (rstN),
		.rn1Id     (rn1Id),
		.rn1Val    (rn1Val),
		.delayKind (delayKind),
		.delayVal  (delayVal),
		.opCancel  (opCancel),
		.wbValid   (wbValid),
		.wbId      (wbId),
		.wbVal     (wbVal)
	);

endmodule

// File: hdl/lane_config.svh
// Lane sizing macros
// Register count, data width, id width, operand field width
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// Architectural register file depth
`define LANE_NREGS 16

// Integer data width
`define LANE_XLEN 32

// Register id width, log2 of LANE_NREGS
`define LANE_IDW 4

// Operand field of an operation word
// Holds either an Rt id or a short immediate
`define LANE_OPNDW 16

`endif

// File: hdl/regFile.sv
// Integer register file
// Two combinational reads, one write, register 0 fixed at zero
`timescale 1ns/10ps
`include "lane_config.svh"

module regFile (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [`LANE_IDW-1:0]  rdIdA,
	input  logic [`LANE_IDW-1:0]  rdIdB,
	output logic [`LANE_XLEN-1:0] rdValA,
	output logic [`LANE_XLEN-1:0] rdValB,
	input  logic                  wrEn,
	input  logic [`LANE_IDW-1:0]  wrId,
	input  logic [`LANE_XLEN-1:0] wrVal
);

	logic [`LANE_XLEN-1:0] regs [`LANE_NREGS];

	// Writes to register 0 dropped
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `LANE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrId != '0)) begin
			regs[wrId] <= wrVal;
		end
	end

	// Register 0 reads zero
	// Pending write visible in the cycle it is presented
	assign rdValA = (rdIdA == '0) ? '0 :
		(wrEn && (wrId == rdIdA)) ? wrVal : regs[rdIdA];
	assign rdValB = (rdIdB == '0) ? '0 :
		(wrEn && (wrId == rdIdB)) ? wrVal : regs[rdIdB];

endmodule

// File: run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module laneTb -o laneSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/laneSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: tb.f
+incdir+hdl
hdl/lanePkg.sv
hdl/regFile.sv
hdl/execStage1.sv
hdl/execStage2.sv
hdl/laneTop.sv
dv/laneMonitor.sv
dv/lane_checker.sv
dv/laneTb.sv
